/* design/flappy_pkg.sv */
package flappy_pkg;

    typedef logic [11:0] coord_t;
    typedef logic [10:0] score_t;
    typedef logic [23:0] rgb_t;
    typedef logic [1:0]  game_mode_t;

    // code 11 falls back to background
    localparam game_mode_t MODE_MENU = 2'b00;
    localparam game_mode_t MODE_PLAY = 2'b01;
    localparam game_mode_t MODE_OVER = 2'b10;

    localparam int NUM_OBST = 3;

    // bird square
    localparam coord_t BIRD_X      = 12'd200;
    localparam coord_t BIRD_SIZE   = 12'd60;
    localparam coord_t BIRD_Y_IDLE = 12'd120;

    // obstacle columns
    localparam coord_t OBST_WIDTH  = 12'd100;
    localparam coord_t GAP_HALF    = 12'd100;
    localparam coord_t OBST_WRAP_X = 12'd1350;
    localparam coord_t OBST_X_INIT [NUM_OBST]   = '{12'd450, 12'd900, 12'd1350};
    localparam coord_t OBST_GAP_INIT [NUM_OBST] = '{12'd450, 12'd150, 12'd300};

    localparam coord_t V_DISP = 12'd768;

    // camera window in the top left corner
    localparam coord_t CAM_X0 = 12'd0;
    localparam coord_t CAM_Y0 = 12'd0;
    localparam coord_t CAM_W  = 12'd200;
    localparam coord_t CAM_H  = 12'd164;

    // collision inset on each side of a column
    localparam coord_t HIT_MARGIN = 12'd10;

    localparam logic [7:0] LFSR_SEED = 8'hA5;

    // gap centres indexed by {lfsr[2], lfsr[5], lfsr[6]}
    localparam coord_t GAP_TABLE [8] = '{
        12'd350, 12'd400, 12'd450, 12'd400,
        12'd600, 12'd200, 12'd250, 12'd300
    };

    localparam rgb_t COLOR_BIRD = 24'hFFFF00;
    localparam rgb_t COLOR_OBST [NUM_OBST] = '{24'hF0F8FF, 24'hF0FFF0, 24'hFFF5EE};
    localparam rgb_t COLOR_BG   = 24'h808080;

endpackage

/* design/game_state_if.sv */
`timescale 1ns/10ps

// bird and obstacle positions updated once per game tick
interface game_state_if;

    flappy_pkg::coord_t bird_y;
    flappy_pkg::coord_t obst_x [flappy_pkg::NUM_OBST];
    // gap centre of each column
    flappy_pkg::coord_t obst_gap [flappy_pkg::NUM_OBST];

    modport engine (
        output bird_y,
        output obst_x,
        output obst_gap
    );

    modport decoder (
        input bird_y,
        input obst_x,
        input obst_gap
    );

endinterface

/* design/pixel_hit_if.sv */
`timescale 1ns/10ps

// registered classification of one pixel
interface pixel_hit_if;

    flappy_pkg::game_mode_t             mode;
    logic                               cam_hit;
    logic                               bird_hit;
    logic [flappy_pkg::NUM_OBST-1:0]    obst_hit;
    // camera sample for the same pixel
    logic [7:0]                         grey;

    modport decoder (
        output mode,
        output cam_hit,
        output bird_hit,
        output obst_hit,
        output grey
    );

    modport composer (
        input mode,
        input cam_hit,
        input bird_hit,
        input obst_hit,
        input grey
    );

endinterface

/* design/game_engine.sv */
`timescale 1ns/10ps

module game_engine #(
    parameter int TICK_DIV = 200000
) (
    input  logic                   clk,
    input  logic                   key1,
    input  logic                   key2,
    input  flappy_pkg::game_mode_t mode,
    game_state_if.engine           state,
    output flappy_pkg::score_t     score,
    output logic                   bird_dead
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    // bird edges used by the collision test
    localparam flappy_pkg::coord_t BIRD_RIGHT =
        flappy_pkg::BIRD_X + flappy_pkg::BIRD_SIZE - flappy_pkg::HIT_MARGIN;
    localparam flappy_pkg::coord_t COL_REACH =
        flappy_pkg::OBST_WIDTH - flappy_pkg::HIT_MARGIN;

    logic [CNT_W-1:0]                tick_cnt;
    logic                            tick;
    logic [7:0]                      lfsr;
    logic [2:0]                      gap_idx;
    logic [flappy_pkg::NUM_OBST-1:0] at_zero;
    logic [flappy_pkg::NUM_OBST-1:0] wrap_sel;
    logic [flappy_pkg::NUM_OBST-1:0] col_hit;
    logic                            crash;

    // game tick divider
    assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // 8-bit gap picker stepped once per tick
    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            lfsr <= flappy_pkg::LFSR_SEED;
        end else if (tick) begin
            lfsr <= {lfsr[6] ^ lfsr[3], lfsr[5] ^ lfsr[7],
                     lfsr[4] ^ lfsr[5], lfsr[3] ^ lfsr[0],
                     lfsr[2] ^ lfsr[4], lfsr[1] ^ lfsr[5],
                     lfsr[0] ^ lfsr[4], lfsr[1] ^ lfsr[6]};
        end
    end

    assign gap_idx = {lfsr[2], lfsr[5], lfsr[6]};

    // climb while key2 is held low
    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            state.bird_y <= flappy_pkg::BIRD_Y_IDLE;
        end else if (tick) begin
            if (mode != flappy_pkg::MODE_PLAY) begin
                state.bird_y <= flappy_pkg::BIRD_Y_IDLE;
            end else if (!key2) begin
                state.bird_y <= state.bird_y - 1'b1;
            end else begin
                state.bird_y <= state.bird_y + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
            at_zero[i] = (state.obst_x[i] == '0);
        end
    end

    // lowest index at the left edge wraps first
    assign wrap_sel = at_zero & ~(at_zero - 1'b1);

    // columns scroll in every mode
    // a wrap freezes the others for that tick
    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
                state.obst_x[i]   <= flappy_pkg::OBST_X_INIT[i];
                state.obst_gap[i] <= flappy_pkg::OBST_GAP_INIT[i];
            end
            score <= '0;
        end else if (tick) begin
            if (|at_zero) begin
                score <= score + 1'b1;
            end
            for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
                if (wrap_sel[i]) begin
                    state.obst_x[i]   <= flappy_pkg::OBST_WRAP_X;
                    state.obst_gap[i] <= flappy_pkg::GAP_TABLE[gap_idx];
                end else if (!(|at_zero)) begin
                    state.obst_x[i] <= state.obst_x[i] - 1'b1;
                end
            end
        end
    end

    // column overlap outside the gap
    always_comb begin
        for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
            col_hit[i] = (BIRD_RIGHT > state.obst_x[i])
                && (flappy_pkg::BIRD_X < state.obst_x[i] + COL_REACH)
                && !((state.bird_y > state.obst_gap[i] - flappy_pkg::GAP_HALF)
                     && (state.bird_y < state.obst_gap[i] + flappy_pkg::GAP_HALF
                                        - flappy_pkg::BIRD_SIZE));
        end
    end

    assign crash = (state.bird_y == 12'd1)
        || (state.bird_y == flappy_pkg::V_DISP)
        || (|col_hit);

    // sticky until key1
    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            bird_dead <= 1'b0;
        end else if (crash) begin
            bird_dead <= 1'b1;
        end
    end

endmodule

/* design/pixel_decode.sv */
`timescale 1ns/10ps

module pixel_decode (
    input  logic                   clk,
    input  logic                   key1,
    input  flappy_pkg::coord_t     lcd_xpos,
    input  flappy_pkg::coord_t     lcd_ypos,
    input  logic [7:0]             bin_data,
    input  flappy_pkg::game_mode_t mode,
    game_state_if.decoder          state,
    pixel_hit_if.decoder           hit
);

    logic                            cam_now;
    logic                            bird_now;
    logic [flappy_pkg::NUM_OBST-1:0] obst_now;

    // base <= pos < base + size
    // the offset wraps when pos is below base
    function automatic logic in_span(
        input flappy_pkg::coord_t pos,
        input flappy_pkg::coord_t base,
        input flappy_pkg::coord_t size
    );
        flappy_pkg::coord_t offset;
        offset = pos - base;
        return offset < size;
    endfunction

    assign cam_now = in_span(lcd_xpos, flappy_pkg::CAM_X0, flappy_pkg::CAM_W)
        && in_span(lcd_ypos, flappy_pkg::CAM_Y0, flappy_pkg::CAM_H);

    assign bird_now = in_span(lcd_xpos, flappy_pkg::BIRD_X, flappy_pkg::BIRD_SIZE)
        && in_span(lcd_ypos, state.bird_y, flappy_pkg::BIRD_SIZE);

    // upper and lower column parts open on both x edges
    always_comb begin
        for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
            obst_now[i] = (lcd_xpos > state.obst_x[i])
                && (lcd_xpos < state.obst_x[i] + flappy_pkg::OBST_WIDTH)
                && ((lcd_ypos <= state.obst_gap[i] - flappy_pkg::GAP_HALF)
                    || ((lcd_ypos >= state.obst_gap[i] + flappy_pkg::GAP_HALF)
                        && (lcd_ypos <= flappy_pkg::V_DISP)));
        end
    end

    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            hit.mode     <= flappy_pkg::MODE_MENU;
            hit.cam_hit  <= 1'b0;
            hit.bird_hit <= 1'b0;
            hit.obst_hit <= '0;
        end else begin
            hit.mode     <= mode;
            hit.cam_hit  <= cam_now;
            hit.bird_hit <= bird_now;
            hit.obst_hit <= obst_now;
        end
    end

    // grey sample stays aligned with its flags
    always_ff @(posedge clk) begin
        hit.grey <= bin_data;
    end

endmodule

/* design/pixel_compose.sv */
`timescale 1ns/10ps

module pixel_compose (
    input  logic              clk,
    input  logic              key1,
    pixel_hit_if.composer     hit,
    output flappy_pkg::rgb_t  lcd_data
);

    flappy_pkg::rgb_t color;

    // lowest priority first so later assignments win
    always_comb begin
        color = flappy_pkg::COLOR_BG;
        if (hit.mode == flappy_pkg::MODE_PLAY) begin
            for (int i = flappy_pkg::NUM_OBST - 1; i >= 0; i--) begin
                if (hit.obst_hit[i]) begin
                    color = flappy_pkg::COLOR_OBST[i];
                end
            end
            if (hit.bird_hit) begin
                color = flappy_pkg::COLOR_BIRD;
            end
        end
        // camera window shows in every mode
        if (hit.cam_hit) begin
            color = {3{hit.grey}};
        end
    end

    always_ff @(posedge clk or negedge key1) begin
        if (!key1) begin
            lcd_data <= '0;
        end else begin
            lcd_data <= color;
        end
    end

endmodule

/* design/flappy_display.sv */
`timescale 1ns/10ps

module flappy_display #(
    parameter int TICK_DIV = 200000
) (
    input  logic               clk,
    input  logic               key1,
    input  logic               key2,
    input  logic [1:0]         state_number,
    input  flappy_pkg::coord_t lcd_xpos,
    input  flappy_pkg::coord_t lcd_ypos,
    input  logic [7:0]         bin_data,
    output flappy_pkg::score_t score,
    output logic               bird_dead,
    output flappy_pkg::rgb_t   lcd_data
);

    game_state_if state_bus ();
    pixel_hit_if  hit_bus ();

    // game step once per tick
    game_engine #(
        .TICK_DIV (TICK_DIV)
    ) u_engine (
        .clk       (clk),
        .key1      (key1),
        .key2      (key2),
        .mode      (state_number),
        .state     (state_bus.engine),
        .score     (score),
        .bird_dead (bird_dead)
    );

    // pixel stage 1
    pixel_decode u_decode (
        .clk      (clk),
        .key1     (key1),
        .lcd_xpos (lcd_xpos),
        .lcd_ypos (lcd_ypos),
        .bin_data (bin_data),
        .mode     (state_number),
        .state    (state_bus.decoder),
        .hit      (hit_bus.decoder)
    );

    // pixel stage 2
    pixel_compose u_compose (
        .clk      (clk),
        .key1     (key1),
        .hit      (hit_bus.composer),
        .lcd_data (lcd_data)
    );

endmodule

/* tests/flappy_properties.sv */
`timescale 1ns/10ps

// engine invariants bound into game_engine
module flappy_properties (
    input logic               clk,
    input logic               key1,
    input flappy_pkg::score_t score,
    input logic               bird_dead,
    input flappy_pkg::coord_t obst_x0,
    input flappy_pkg::coord_t obst_x1,
    input flappy_pkg::coord_t obst_x2
);

    // one wrap per tick at most
    a_score_step: assert property (
        @(posedge clk) disable iff (!key1)
        (score == $past(score)) || (score == flappy_pkg::score_t'($past(score) + 1'b1))
    ) else $error("score rose by more than one in a clock");

    a_dead_sticky: assert property (
        @(posedge clk) disable iff (!key1)
        $past(bird_dead) |-> bird_dead
    ) else $error("bird_dead fell without reset");

    // columns never start right of the wrap point
    a_wrap_limit: assert property (
        @(posedge clk) disable iff (!key1)
        (obst_x0 <= flappy_pkg::OBST_WRAP_X) && (obst_x1 <= flappy_pkg::OBST_WRAP_X)
            && (obst_x2 <= flappy_pkg::OBST_WRAP_X)
    ) else $error("obstacle x beyond the wrap position");

endmodule

bind game_engine flappy_properties u_props (
    .clk       (clk),
    .key1      (key1),
    .score     (score),
    .bird_dead (bird_dead),
    .obst_x0   (state.obst_x[0]),
    .obst_x1   (state.obst_x[1]),
    .obst_x2   (state.obst_x[2])
);

/* tests/tb_flappy.sv */
`timescale 1ns/10ps

module tb_flappy;

    localparam int TICK_DIV      = 16;
    localparam int WRAP_TIMEOUT  = 10000;
    localparam int RUN_CYCLES    = 30000;
    localparam int DEATH_TIMEOUT = 4000;

    localparam int BIRD_X     = flappy_pkg::BIRD_X;
    localparam int BIRD_SIZE  = flappy_pkg::BIRD_SIZE;
    localparam int OBST_WIDTH = flappy_pkg::OBST_WIDTH;
    localparam int GAP_HALF   = flappy_pkg::GAP_HALF;
    localparam int HIT_MARGIN = flappy_pkg::HIT_MARGIN;
    localparam int V_DISP     = flappy_pkg::V_DISP;
    localparam int CAM_X0     = flappy_pkg::CAM_X0;
    localparam int CAM_Y0     = flappy_pkg::CAM_Y0;
    localparam int CAM_W      = flappy_pkg::CAM_W;
    localparam int CAM_H      = flappy_pkg::CAM_H;

    logic               clk;
    logic               key1;
    logic               key2;
    logic [1:0]         state_number;
    flappy_pkg::coord_t lcd_xpos;
    flappy_pkg::coord_t lcd_ypos;
    logic [7:0]         bin_data;
    flappy_pkg::score_t score;
    logic               bird_dead;
    flappy_pkg::rgb_t   lcd_data;

    // reference model of the engine and the pixel pipe
    integer             seed = 32'h991a_560a;
    int                 m_cnt;
    logic [7:0]         m_lfsr;
    flappy_pkg::coord_t m_bird_y;
    flappy_pkg::coord_t m_ox [flappy_pkg::NUM_OBST];
    flappy_pkg::coord_t m_gap [flappy_pkg::NUM_OBST];
    flappy_pkg::score_t m_score;
    logic               m_dead;
    flappy_pkg::rgb_t   pix_q [$];
    flappy_pkg::rgb_t   exp_pixel;
    logic               model_ready = 1'b0;
    // forces play and steers the bird to the top edge
    logic               dive = 1'b0;

    int pixel_errors   = 0;
    int score_errors   = 0;
    int dead_errors    = 0;
    int timeout_errors = 0;

    flappy_display #(
        .TICK_DIV (TICK_DIV)
    ) DUT (
        .clk          (clk),
        .key1         (key1),
        .key2         (key2),
        .state_number (state_number),
        .lcd_xpos     (lcd_xpos),
        .lcd_ypos     (lcd_ypos),
        .bin_data     (bin_data),
        .score        (score),
        .bird_dead    (bird_dead),
        .lcd_data     (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // feedback of the board's 8-bit shift register
    function automatic logic [7:0] lfsr_step(input logic [7:0] r);
        return {r[6] ^ r[3], r[5] ^ r[7], r[4] ^ r[5], r[3] ^ r[0],
                r[2] ^ r[4], r[1] ^ r[5], r[0] ^ r[4], r[1] ^ r[6]};
    endfunction

    function automatic logic [1:0] pick_mode();
        case (rnd(8))
            0:       return flappy_pkg::MODE_MENU;
            1:       return flappy_pkg::MODE_OVER;
            2:       return 2'b11;
            default: return flappy_pkg::MODE_PLAY;
        endcase
    endfunction

    function automatic logic crash_now();
        int  y;
        int  ox;
        int  g;
        logic hit;
        y   = m_bird_y;
        hit = (y == 1) || (y == V_DISP);
        for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
            ox = m_ox[i];
            g  = m_gap[i];
            if ((BIRD_X + BIRD_SIZE - HIT_MARGIN > ox) && (BIRD_X < ox + OBST_WIDTH - HIT_MARGIN)
                && !((y > g - GAP_HALF) && (y < g + GAP_HALF - BIRD_SIZE))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // camera first, then bird and columns in play, then background
    function automatic flappy_pkg::rgb_t expected_color(
        input int xi,
        input int yi,
        input logic [7:0] grey,
        input logic [1:0] mode
    );
        flappy_pkg::rgb_t c;
        int  by;
        int  ox;
        int  g;
        logic found;
        c     = flappy_pkg::COLOR_BG;
        by    = m_bird_y;
        found = 1'b0;
        if (xi >= CAM_X0 && xi < CAM_X0 + CAM_W && yi >= CAM_Y0 && yi < CAM_Y0 + CAM_H) begin
            c = {3{grey}};
        end else if (mode == flappy_pkg::MODE_PLAY) begin
            if (xi >= BIRD_X && xi < BIRD_X + BIRD_SIZE && yi >= by && yi < by + BIRD_SIZE) begin
                c     = flappy_pkg::COLOR_BIRD;
                found = 1'b1;
            end
            for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
                ox = m_ox[i];
                g  = m_gap[i];
                if (!found && xi > ox && xi < ox + OBST_WIDTH
                    && (yi <= g - GAP_HALF || (yi >= g + GAP_HALF && yi <= V_DISP))) begin
                    c     = flappy_pkg::COLOR_OBST[i];
                    found = 1'b1;
                end
            end
        end
        return c;
    endfunction

    // one game step on a tick
    task automatic advance_game();
        logic [7:0] prev;
        int         wrap_i;
        prev   = m_lfsr;
        m_lfsr = lfsr_step(m_lfsr);
        if (state_number != flappy_pkg::MODE_PLAY) begin
            m_bird_y = flappy_pkg::BIRD_Y_IDLE;
        end else if (!key2) begin
            m_bird_y = m_bird_y - 12'd1;
        end else begin
            m_bird_y = m_bird_y + 12'd1;
        end
        wrap_i = -1;
        for (int i = flappy_pkg::NUM_OBST - 1; i >= 0; i--) begin
            if (m_ox[i] == 0) begin
                wrap_i = i;
            end
        end
        if (wrap_i >= 0) begin
            m_ox[wrap_i]  = flappy_pkg::OBST_WRAP_X;
            m_gap[wrap_i] = flappy_pkg::GAP_TABLE[{prev[2], prev[5], prev[6]}];
            m_score       = m_score + 1'b1;
        end else begin
            for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
                m_ox[i] = m_ox[i] - 12'd1;
            end
        end
    endtask

    // coordinates biased into the camera, bird and column edges
    task automatic pick_pixel(output int xi, output int yi);
        int k;
        case (rnd(4))
            0: begin
                xi = rnd(CAM_W + 20);
                yi = rnd(CAM_H + 20);
            end
            1: begin
                xi = BIRD_X - 3 + rnd(BIRD_SIZE + 6);
                yi = m_bird_y - 3 + rnd(BIRD_SIZE + 6);
            end
            2: begin
                k  = rnd(flappy_pkg::NUM_OBST);
                xi = m_ox[k] - 2 + rnd(OBST_WIDTH + 4);
                case (rnd(3))
                    0:       yi = m_gap[k] - GAP_HALF - 2 + rnd(5);
                    1:       yi = m_gap[k] + GAP_HALF - 2 + rnd(5);
                    default: yi = V_DISP - 2 + rnd(5);
                endcase
            end
            default: begin
                xi = rnd(1500);
                yi = rnd(800);
            end
        endcase
        if (xi < 0) begin
            xi = 0;
        end
        if (yi < 0) begin
            yi = 0;
        end
    endtask

    // model steps on the same edge the DUT does, then drives the next stimulus
    always @(posedge clk or negedge key1) begin
        int         nx;
        int         ny;
        logic [7:0] nbin;
        logic [1:0] nmode;
        if (!key1) begin
            m_cnt    = 0;
            m_lfsr   = flappy_pkg::LFSR_SEED;
            m_bird_y = flappy_pkg::BIRD_Y_IDLE;
            for (int i = 0; i < flappy_pkg::NUM_OBST; i++) begin
                m_ox[i]  = flappy_pkg::OBST_X_INIT[i];
                m_gap[i] = flappy_pkg::OBST_GAP_INIT[i];
            end
            m_score   = '0;
            m_dead    = 1'b0;
            exp_pixel = '0;
            pix_q.delete();
            // composer shows background for its first cycle out of reset
            pix_q.push_back(flappy_pkg::COLOR_BG);
            model_ready = 1'b1;
        end else begin
            if (crash_now()) begin
                m_dead = 1'b1;
            end
            if (m_cnt == TICK_DIV - 1) begin
                m_cnt = 0;
                advance_game();
                if (dive && m_bird_y > 1) begin
                    key2 <= 1'b0;
                end else if (m_bird_y < 30) begin
                    key2 <= 1'b1;
                end else if (m_bird_y > 700) begin
                    key2 <= 1'b0;
                end else begin
                    key2 <= rnd(2);
                end
            end else begin
                m_cnt++;
            end
        end
        nmode = state_number;
        if (dive) begin
            nmode = flappy_pkg::MODE_PLAY;
        end else if (rnd(2048) == 0) begin
            nmode = pick_mode();
        end
        pick_pixel(nx, ny);
        nbin = rnd(256);
        state_number <= nmode;
        lcd_xpos     <= nx;
        lcd_ypos     <= ny;
        bin_data     <= nbin;
        pix_q.push_back(expected_color(nx, ny, nbin, nmode));
        if (pix_q.size() > 2) begin
            exp_pixel = pix_q.pop_front();
        end
    end

    task automatic check_pixel(input flappy_pkg::rgb_t got, input flappy_pkg::rgb_t want);
        if (got !== want) begin
            pixel_errors++;
            $display("CHECK FAILED t=%0t lcd_data is %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_score(input flappy_pkg::score_t got, input flappy_pkg::score_t want);
        if (got !== want) begin
            score_errors++;
            $display("CHECK FAILED t=%0t score is %0d, expected %0d", $time, got, want);
        end
    endtask

    task automatic check_dead(input logic got, input logic want);
        if (got !== want) begin
            dead_errors++;
            $display("CHECK FAILED t=%0t bird_dead is %b, expected %b", $time, got, want);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (model_ready) begin
            check_pixel(lcd_data, exp_pixel);
            check_score(score, m_score);
            check_dead(bird_dead, m_dead);
        end
    end

    initial begin
        int waited;
        key1         = 1'b0;
        key2         = 1'b1;
        state_number = flappy_pkg::MODE_PLAY;
        lcd_xpos     = '0;
        lcd_ypos     = '0;
        bin_data     = '0;
        repeat (4) @(posedge clk);
        key1 <= 1'b1;
        @(negedge clk);
        check_score(score, '0);
        check_dead(bird_dead, 1'b0);
        check_pixel(lcd_data, '0);

        waited = 0;
        while (score == 0 && waited < WRAP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (score == 0) begin
            timeout_errors++;
            $display("timeout: no obstacle wrapped within %0d cycles", WRAP_TIMEOUT);
        end else begin
            repeat (RUN_CYCLES) @(posedge clk);
            // second reset and a climb until the top edge kills the bird
            dive <= 1'b1;
            key1 <= 1'b0;
            repeat (4) @(posedge clk);
            key1 <= 1'b1;
            waited = 0;
            while (!bird_dead && waited < DEATH_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!bird_dead) begin
                timeout_errors++;
                $display("timeout: bird never died at the top edge within %0d cycles",
                         DEATH_TIMEOUT);
            end else begin
                repeat (400) @(posedge clk);
            end
        end

        $display("error counts: pixel %0d, score %0d, dead %0d, timeout %0d",
                 pixel_errors, score_errors, dead_errors, timeout_errors);
        if (pixel_errors + score_errors + dead_errors + timeout_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
design/flappy_pkg.sv
design/game_state_if.sv
design/pixel_hit_if.sv
design/game_engine.sv
design/pixel_decode.sv
design/pixel_compose.sv
design/flappy_display.sv
tests/flappy_properties.sv
tests/tb_flappy.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the flappy testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_flappy -f sources.f \
    -o sim_flappy > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_flappy > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
